// ==== cache_axi_bridge.f ====
source/axi_bridge_pkg.sv
source/req_skid.sv
source/read_arbiter.sv
source/burst_reader.sv
source/burst_writer.sv
source/cache_axi_bridge.sv
sim/tb_clock.sv
sim/axi_mem_model.sv
sim/tb_cache_axi_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cache_axi_bridge \
    -f cache_axi_bridge.f -o sim_bin
./obj_dir/sim_bin > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation passed" sim.log

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                    aclk,
    input  logic                    rst,
    input  logic                    arvalid,
    output logic                    arready,
    input  axi_bridge_pkg::axi_ar_t ar,
    output logic                    rvalid,
    input  logic                    rready,
    output axi_bridge_pkg::axi_r_t  r,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_bridge_pkg::axi_aw_t aw,
    input  logic                    wvalid,
    output logic                    wready,
    input  axi_bridge_pkg::axi_w_t  w,
    output logic                    bvalid,
    input  logic                    bready,
    output axi_bridge_pkg::axi_b_t  b
);

    logic [31:0] mem [1024];
    logic [31:0] shadow [1024];
    logic [31:0] lfsr;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] s3;
    logic [31:0] s4;
    logic [31:0] s5;
    logic        rd_busy;
    logic [31:0] rd_addr;
    logic [3:0]  rd_id;
    logic [2:0]  rd_cnt;
    logic        wr_busy;
    logic        b_pend;
    logic [31:0] wr_addr;
    logic [3:0]  wr_id;
    logic [2:0]  wr_cnt;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i]    = (32'(i) * 32'h9e3779b1) ^ 32'h5eed0000;
            shadow[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5eed0000;
        end
    end

    // one lfsr step per random bit
    assign s1 = lfsr_step(lfsr);
    assign s2 = lfsr_step(s1);
    assign s3 = lfsr_step(s2);
    assign s4 = lfsr_step(s3);
    assign s5 = lfsr_step(s4);

    assign arready = !rd_busy && s1[0];
    assign awready = !wr_busy && s3[0];
    assign wready  = wr_busy && !b_pend && s4[0];

    assign r.id   = rd_id;
    assign r.data = mem[rd_addr[11:2] + 10'(rd_cnt)];
    assign r.resp = (rd_addr >= 32'h800) ? 2'd2 : axi_bridge_pkg::resp_okay;
    assign r.last = (rd_cnt == 3'd7);
    assign b.id   = wr_id;
    assign b.resp = axi_bridge_pkg::resp_okay;

    always @(posedge aclk) begin
        if (rst) begin
            lfsr    <= 32'hb86b;
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            lfsr <= s5;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_addr <= ar.addr;
                rd_id   <= ar.id;
                rd_cnt  <= 3'd0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                rd_cnt <= rd_cnt + 3'd1;
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end else if (rd_busy && !rvalid && s2[0]) begin
                rvalid <= 1'b1;
            end
            if (awvalid && awready) begin
                wr_busy <= 1'b1;
                wr_addr <= aw.addr;
                wr_id   <= aw.id;
                wr_cnt  <= 3'd0;
            end
            if (wvalid && wready) begin
                mem[wr_addr[11:2] + 10'(wr_cnt)]    <= w.data;
                shadow[wr_addr[11:2] + 10'(wr_cnt)] <= w.data;
                wr_cnt <= wr_cnt + 3'd1;
                b_pend <= w.last;
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                b_pend  <= 1'b0;
                wr_busy <= 1'b0;
            end else if (b_pend && !bvalid && s5[0]) begin
                bvalid <= 1'b1;
            end
        end
    end

endmodule

// ==== sim/tb_cache_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_cache_axi_bridge;

    localparam int n_lines = 11;

    logic aclk;
    logic rst;
    logic inst_rd_req_valid;
    logic inst_rd_req_ready;
    logic inst_rd_rsp_valid;
    logic inst_rd_rsp_ready;
    logic data_rd_req_valid;
    logic data_rd_req_ready;
    logic data_rd_rsp_valid;
    logic data_rd_rsp_ready;
    logic data_wr_req_valid;
    logic data_wr_req_ready;
    logic data_wr_done;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    axi_bridge_pkg::line_rd_req_t inst_rd_req;
    axi_bridge_pkg::line_rd_req_t data_rd_req;
    axi_bridge_pkg::line_rd_rsp_t inst_rd_rsp;
    axi_bridge_pkg::line_rd_rsp_t data_rd_rsp;
    axi_bridge_pkg::line_wr_req_t data_wr_req;
    axi_bridge_pkg::axi_ar_t      ar;
    axi_bridge_pkg::axi_r_t       r;
    axi_bridge_pkg::axi_aw_t      aw;
    axi_bridge_pkg::axi_w_t       w;
    axi_bridge_pkg::axi_b_t       b;

    int          errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          w_beats = 0;
    logic [2:0]  w_cnt;
    logic [3:0]  ar_ids [$];
    logic        inst_only = 1'b0;
    logic        hold_mode = 1'b0;

    tb_clock clock_gen (.aclk(aclk), .rst(rst));

    cache_axi_bridge UUT (.*);

    axi_mem_model mem_model (.*);

    initial begin
        inst_rd_req_valid = 1'b0;
        inst_rd_req       = '0;
        inst_rd_rsp_ready = 1'b1;
        data_rd_req_valid = 1'b0;
        data_rd_req       = '0;
        data_rd_rsp_ready = 1'b1;
        data_wr_req_valid = 1'b0;
        data_wr_req       = '0;
    end

    always @(posedge aclk) begin
        if (arvalid && arready) begin
            ar_ids.push_back(ar.id);
        end
        if (rst) begin
            w_cnt <= 3'd0;
        end else if (wvalid && wready) begin
            w_cnt   <= w_cnt + 3'd1;
            w_beats <= w_beats + 1;
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        wvalid && wready |-> w.strb == 4'hf && w.last == (w_cnt == 3'd7))
        else begin
            errors++;
            $display("MISMATCH w_beat expected %h actual %h",
                     {4'hf, $sampled(w_cnt) == 3'd7}, $sampled({w.strb, w.last}));
        end

    // data id, 8 beats, word size, incr
    assert property (@(posedge aclk) disable iff (rst)
        awvalid |-> {aw.id, aw.len, aw.size, aw.burst} == {4'd1, 8'd7, 3'd2, 2'd1})
        else begin
            errors++;
            $display("MISMATCH aw_attr expected %h actual %h",
                     {4'd1, 8'd7, 3'd2, 2'd1},
                     $sampled({aw.id, aw.len, aw.size, aw.burst}));
        end

    assert property (@(posedge aclk) disable iff (rst)
        arvalid |-> {ar.len, ar.size, ar.burst} == {8'd7, 3'd2, 2'd1})
        else begin
            errors++;
            $display("MISMATCH ar_attr expected %h actual %h",
                     {8'd7, 3'd2, 2'd1}, $sampled({ar.len, ar.size, ar.burst}));
        end

    assert property (@(posedge aclk) disable iff (rst)
        inst_only |-> !data_rd_rsp_valid)
        else begin
            errors++;
            $display("data response raised during an instruction read");
        end

    // held response must stay put and block new reads
    assert property (@(posedge aclk) disable iff (rst)
        hold_mode |=> data_rd_rsp_valid && !arvalid && $stable(data_rd_rsp))
        else begin
            errors++;
            $display("response moved or a new read started while held");
        end

    initial begin
        repeat (10 + 200 * n_lines) @(posedge aclk);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [255:0] exp,
                             input logic [255:0] act);
        assert (exp === act)
            else begin
                errors++;
                $display("MISMATCH %s expected %h actual %h", name, exp, act);
            end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s failed", name);
        end
    endtask

    function automatic logic [255:0] shadow_line(input logic [31:0] addr);
        logic [255:0] line;
        for (int i = 0; i < 8; i++) begin
            line[i*32 +: 32] = mem_model.shadow[addr[11:2] + 10'(i)];
        end
        return line;
    endfunction

    task automatic read_line(input logic is_data, input logic [31:0] addr, input int hold,
                             output axi_bridge_pkg::line_rd_rsp_t rsp);
        @(posedge aclk);
        if (is_data) begin
            data_rd_req_valid <= 1'b1;
            data_rd_req.addr  <= addr;
            data_rd_rsp_ready <= (hold == 0);
        end else begin
            inst_rd_req_valid <= 1'b1;
            inst_rd_req.addr  <= addr;
        end
        do @(negedge aclk); while (!(is_data ? data_rd_req_ready : inst_rd_req_ready));
        @(posedge aclk);
        if (is_data) begin
            data_rd_req_valid <= 1'b0;
        end else begin
            inst_rd_req_valid <= 1'b0;
        end
        do @(negedge aclk); while (!(is_data ? data_rd_rsp_valid : inst_rd_rsp_valid));
        rsp = is_data ? data_rd_rsp : inst_rd_rsp;
        if (hold > 0) begin
            hold_mode = 1'b1;
            repeat (hold) @(negedge aclk);
            hold_mode = 1'b0;
            check_val("held_rsp", {rsp.data}, {data_rd_rsp.data});
            @(posedge aclk);
            data_rd_rsp_ready <= 1'b1;
        end
        @(posedge aclk);
    endtask

    // two requests queued back to back in one skid
    task automatic queue_two_reads(input logic is_data, input logic [31:0] addr0,
                                   input logic [31:0] addr1, output logic [255:0] line0,
                                   output logic [255:0] line1);
        @(posedge aclk);
        if (is_data) begin
            data_rd_req_valid <= 1'b1;
            data_rd_req.addr  <= addr0;
        end else begin
            inst_rd_req_valid <= 1'b1;
            inst_rd_req.addr  <= addr0;
        end
        do @(negedge aclk); while (!(is_data ? data_rd_req_ready : inst_rd_req_ready));
        @(posedge aclk);
        if (is_data) begin
            data_rd_req.addr <= addr1;
        end else begin
            inst_rd_req.addr <= addr1;
        end
        do @(negedge aclk); while (!(is_data ? data_rd_req_ready : inst_rd_req_ready));
        @(posedge aclk);
        if (is_data) begin
            data_rd_req_valid <= 1'b0;
        end else begin
            inst_rd_req_valid <= 1'b0;
        end
        do @(negedge aclk); while (!(is_data ? data_rd_rsp_valid : inst_rd_rsp_valid));
        line0 = is_data ? data_rd_rsp.data : inst_rd_rsp.data;
        @(posedge aclk);
        do @(negedge aclk); while (!(is_data ? data_rd_rsp_valid : inst_rd_rsp_valid));
        line1 = is_data ? data_rd_rsp.data : inst_rd_rsp.data;
        @(posedge aclk);
    endtask

    task automatic write_line(input logic [31:0] addr, input logic [255:0] data);
        @(posedge aclk);
        data_wr_req_valid <= 1'b1;
        data_wr_req       <= '{addr: addr, data: data};
        do @(negedge aclk); while (!data_wr_req_ready);
        @(posedge aclk);
        data_wr_req_valid <= 1'b0;
        do @(negedge aclk); while (!data_wr_done);
        @(negedge aclk);
        check_val("wr_done_pulse", 256'd0, {255'd0, data_wr_done});
    endtask

    initial begin
        axi_bridge_pkg::line_rd_rsp_t rsp_a;
        axi_bridge_pkg::line_rd_rsp_t rsp_b;
        logic [255:0]                 wdata;
        logic [255:0]                 inst_line0;
        logic [255:0]                 inst_line1;
        logic [255:0]                 data_line0;
        logic [255:0]                 data_line1;
        int                           e0;

        @(negedge rst);
        @(negedge aclk);
        e0 = errors;
        check_val("reset_valids", 256'd0,
                  {251'd0, arvalid, awvalid, wvalid, inst_rd_rsp_valid, data_rd_rsp_valid});
        check_val("reset_readys", 256'd7,
                  {253'd0, inst_rd_req_ready, data_rd_req_ready, data_wr_req_ready});
        end_test("reset", e0);

        e0 = errors;
        inst_only = 1'b1;
        read_line(1'b0, 32'h40, 0, rsp_a);
        inst_only = 1'b0;
        check_val("inst_line", shadow_line(32'h40), rsp_a.data);
        check_val("inst_err", 256'd0, {255'd0, rsp_a.err});
        end_test("inst_read", e0);

        e0 = errors;
        ar_ids.delete();
        fork
            queue_two_reads(1'b0, 32'h80, 32'ha0, inst_line0, inst_line1);
            queue_two_reads(1'b1, 32'hc0, 32'he0, data_line0, data_line1);
        join
        check_val("both_inst0", shadow_line(32'h80), inst_line0);
        check_val("both_inst1", shadow_line(32'ha0), inst_line1);
        check_val("both_data0", shadow_line(32'hc0), data_line0);
        check_val("both_data1", shadow_line(32'he0), data_line1);
        check_val("ar_count", 256'd4, 256'(ar_ids.size()));
        for (int i = 1; i < 4; i++) begin
            check_val("arid_alternate", 256'(ar_ids[i-1] ^ 4'd1), 256'(ar_ids[i]));
        end
        end_test("dual_read", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            wdata[i*32 +: 32] = 32'hc0de0000 | 32'(i * 17);
        end
        w_beats = 0;
        write_line(32'h100, wdata);
        check_val("w_beats", 256'd8, 256'(w_beats));
        read_line(1'b1, 32'h100, 0, rsp_a);
        check_val("readback", wdata, rsp_a.data);
        end_test("writeback", e0);

        // an instruction read waits behind the held response
        e0 = errors;
        fork
            read_line(1'b1, 32'h140, 20, rsp_a);
            begin
                repeat (4) @(posedge aclk);
                read_line(1'b0, 32'h180, 0, rsp_b);
            end
        join
        check_val("held_line", shadow_line(32'h140), rsp_a.data);
        check_val("queued_inst", shadow_line(32'h180), rsp_b.data);
        end_test("rsp_hold", e0);

        e0 = errors;
        read_line(1'b1, 32'h900, 0, rsp_a);
        check_val("err_region", 256'd1, {255'd0, rsp_a.err});
        read_line(1'b0, 32'h200, 0, rsp_b);
        check_val("ok_region", 256'd0, {255'd0, rsp_b.err});
        end_test("error_region", e0);

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (errors == 0 && n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic aclk,
    output logic rst
);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // reset held for 10 cycles
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge aclk);
        rst <= 1'b0;
    end

endmodule

// ==== source/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    localparam int addr_w     = 32;
    localparam int word_w     = 32;
    localparam int line_words = 8;
    localparam int line_w     = 256;
    localparam int id_w       = 4;
    localparam int strb_w     = word_w / 8;
    localparam int beat_w     = $clog2(line_words);

    // axi ids per requester
    localparam logic [id_w-1:0] inst_id = 4'd0;
    localparam logic [id_w-1:0] data_id = 4'd1;

    localparam logic [7:0] burst_len  = 8'(line_words - 1);
    localparam logic [2:0] size_word  = 3'd2;
    localparam logic [1:0] burst_incr = 2'd1;
    localparam logic [1:0] resp_okay  = 2'd0;

    localparam logic [beat_w-1:0] last_beat = beat_w'(line_words - 1);

    typedef struct packed {
        logic [addr_w-1:0] addr;
    } line_rd_req_t;

    typedef struct packed {
        logic [line_w-1:0] data;
        logic              err;
    } line_rd_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [line_w-1:0] data;
    } line_wr_req_t;

    // aw shares this layout
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [word_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [word_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

endpackage

// ==== source/burst_reader.sv ====
`timescale 1ns/1ps

module burst_reader (
    input  logic                            aclk,
    input  logic                            rst,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  axi_bridge_pkg::line_rd_req_t    req,
    input  logic [axi_bridge_pkg::id_w-1:0] req_id,
    output logic                            ar_valid,
    input  logic                            ar_ready,
    output axi_bridge_pkg::axi_ar_t         ar,
    input  logic                            r_valid,
    output logic                            r_ready,
    input  axi_bridge_pkg::axi_r_t          r,
    output logic                            inst_rsp_valid,
    input  logic                            inst_rsp_ready,
    output logic                            data_rsp_valid,
    input  logic                            data_rsp_ready,
    output axi_bridge_pkg::line_rd_rsp_t    rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_beats,
        st_resp
    } state_t;

    state_t                                 state;
    logic [axi_bridge_pkg::addr_w-1:0]      addr_q;
    logic [axi_bridge_pkg::id_w-1:0]        id_q;
    logic [axi_bridge_pkg::beat_w-1:0]      beat_cnt;
    logic [axi_bridge_pkg::line_w-1:0]      line_q;
    logic                                   err_q;
    logic                                   rsp_ready;
    logic                                   beat;

    assign req_ready = (state == st_idle);
    assign ar_valid  = (state == st_addr);
    assign r_ready   = (state == st_beats);
    assign beat      = r_valid && r_ready;

    assign ar.id    = id_q;
    assign ar.addr  = addr_q;
    assign ar.len   = axi_bridge_pkg::burst_len;
    assign ar.size  = axi_bridge_pkg::size_word;
    assign ar.burst = axi_bridge_pkg::burst_incr;

    // owner picked by the held id
    assign inst_rsp_valid = (state == st_resp) && (id_q == axi_bridge_pkg::inst_id);
    assign data_rsp_valid = (state == st_resp) && (id_q == axi_bridge_pkg::data_id);
    assign rsp_ready      = (id_q == axi_bridge_pkg::inst_id) ? inst_rsp_ready
                                                              : data_rsp_ready;

    assign rsp.data = line_q;
    assign rsp.err  = err_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= st_idle;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (ar_ready) begin
                        state    <= st_beats;
                        beat_cnt <= '0;
                        err_q    <= 1'b0;
                    end
                end
                st_beats: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        err_q    <= err_q | (r.resp != axi_bridge_pkg::resp_okay);
                        if (beat_cnt == axi_bridge_pkg::last_beat) begin
                            state <= st_resp;
                        end
                    end
                end
                default: begin
                    if (rsp_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            addr_q <= req.addr;
            id_q   <= req_id;
        end
        // word 0 ends up in the low bits
        if (beat) begin
            line_q <= {r.data, line_q[axi_bridge_pkg::line_w-1:axi_bridge_pkg::word_w]};
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        beat |-> r.id == id_q);

    assert property (@(posedge aclk) disable iff (rst)
        beat |-> r.last == (beat_cnt == axi_bridge_pkg::last_beat));

endmodule

// ==== source/burst_writer.sv ====
`timescale 1ns/1ps

module burst_writer (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  axi_bridge_pkg::line_wr_req_t req,
    output logic                         aw_valid,
    input  logic                         aw_ready,
    output axi_bridge_pkg::axi_aw_t      aw,
    output logic                         w_valid,
    input  logic                         w_ready,
    output axi_bridge_pkg::axi_w_t       w,
    input  logic                         b_valid,
    output logic                         b_ready,
    input  axi_bridge_pkg::axi_b_t       b,
    output logic                         wr_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp
    } state_t;

    state_t                                 state;
    logic [axi_bridge_pkg::addr_w-1:0]      addr_q;
    logic [axi_bridge_pkg::line_w-1:0]      line_q;
    logic [axi_bridge_pkg::beat_w-1:0]      beat_cnt;
    logic                                   w_beat;

    assign req_ready = (state == st_idle);
    assign aw_valid  = (state == st_addr);
    assign w_valid   = (state == st_data);
    assign b_ready   = (state == st_resp);
    assign w_beat    = w_valid && w_ready;

    // writebacks always carry the data id
    assign aw.id    = axi_bridge_pkg::data_id;
    assign aw.addr  = addr_q;
    assign aw.len   = axi_bridge_pkg::burst_len;
    assign aw.size  = axi_bridge_pkg::size_word;
    assign aw.burst = axi_bridge_pkg::burst_incr;

    assign w.data = line_q[axi_bridge_pkg::word_w-1:0];
    assign w.strb = '1;
    assign w.last = (beat_cnt == axi_bridge_pkg::last_beat);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= st_idle;
            beat_cnt <= '0;
            wr_done  <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (aw_ready) begin
                        state    <= st_data;
                        beat_cnt <= '0;
                    end
                end
                st_data: begin
                    if (w_beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (w.last) begin
                            state <= st_resp;
                        end
                    end
                end
                default: begin
                    if (b_valid) begin
                        state   <= st_idle;
                        wr_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // line drains low word first
    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            addr_q <= req.addr;
            line_q <= req.data;
        end else if (w_beat) begin
            line_q <= line_q >> axi_bridge_pkg::word_w;
        end
    end

    // first W of a burst follows its AW handshake
    assert property (@(posedge aclk) disable iff (rst)
        w_valid && !$past(w_valid) |-> $past(aw_valid && aw_ready));

    assert property (@(posedge aclk) disable iff (rst)
        b_valid && b_ready |-> b.id == axi_bridge_pkg::data_id);

endmodule

// ==== source/cache_axi_bridge.sv ====
`timescale 1ns/1ps

module cache_axi_bridge (
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         inst_rd_req_valid,
    output logic                         inst_rd_req_ready,
    input  axi_bridge_pkg::line_rd_req_t inst_rd_req,
    output logic                         inst_rd_rsp_valid,
    input  logic                         inst_rd_rsp_ready,
    output axi_bridge_pkg::line_rd_rsp_t inst_rd_rsp,
    input  logic                         data_rd_req_valid,
    output logic                         data_rd_req_ready,
    input  axi_bridge_pkg::line_rd_req_t data_rd_req,
    output logic                         data_rd_rsp_valid,
    input  logic                         data_rd_rsp_ready,
    output axi_bridge_pkg::line_rd_rsp_t data_rd_rsp,
    input  logic                         data_wr_req_valid,
    output logic                         data_wr_req_ready,
    input  axi_bridge_pkg::line_wr_req_t data_wr_req,
    output logic                         data_wr_done,
    output logic                         arvalid,
    input  logic                         arready,
    output axi_bridge_pkg::axi_ar_t      ar,
    input  logic                         rvalid,
    output logic                         rready,
    input  axi_bridge_pkg::axi_r_t       r,
    output logic                         awvalid,
    input  logic                         awready,
    output axi_bridge_pkg::axi_aw_t      aw,
    output logic                         wvalid,
    input  logic                         wready,
    output axi_bridge_pkg::axi_w_t       w,
    input  logic                         bvalid,
    output logic                         bready,
    input  axi_bridge_pkg::axi_b_t       b
);

    logic                            inst_skid_valid;
    logic                            inst_skid_ready;
    axi_bridge_pkg::line_rd_req_t    inst_skid_req;
    logic                            data_skid_valid;
    logic                            data_skid_ready;
    axi_bridge_pkg::line_rd_req_t    data_skid_req;
    logic                            wr_skid_valid;
    logic                            wr_skid_ready;
    axi_bridge_pkg::line_wr_req_t    wr_skid_req;
    logic                            grant_valid;
    logic                            grant_ready;
    axi_bridge_pkg::line_rd_req_t    grant_req;
    logic [axi_bridge_pkg::id_w-1:0] grant_id;
    axi_bridge_pkg::line_rd_rsp_t    rd_rsp;

    // both read owners see the same line, valid picks the owner
    assign inst_rd_rsp = rd_rsp;
    assign data_rd_rsp = rd_rsp;

    req_skid #(.payload_t(axi_bridge_pkg::line_rd_req_t)) inst_skid (
        .aclk(aclk), .rst(rst),
        .in_valid(inst_rd_req_valid), .in_ready(inst_rd_req_ready), .in_data(inst_rd_req),
        .out_valid(inst_skid_valid), .out_ready(inst_skid_ready), .out_data(inst_skid_req)
    );

    req_skid #(.payload_t(axi_bridge_pkg::line_rd_req_t)) data_skid (
        .aclk(aclk), .rst(rst),
        .in_valid(data_rd_req_valid), .in_ready(data_rd_req_ready), .in_data(data_rd_req),
        .out_valid(data_skid_valid), .out_ready(data_skid_ready), .out_data(data_skid_req)
    );

    req_skid #(.payload_t(axi_bridge_pkg::line_wr_req_t)) wr_skid (
        .aclk(aclk), .rst(rst),
        .in_valid(data_wr_req_valid), .in_ready(data_wr_req_ready), .in_data(data_wr_req),
        .out_valid(wr_skid_valid), .out_ready(wr_skid_ready), .out_data(wr_skid_req)
    );

    read_arbiter arbiter (
        .aclk(aclk), .rst(rst),
        .inst_valid(inst_skid_valid), .inst_ready(inst_skid_ready), .inst_req(inst_skid_req),
        .data_valid(data_skid_valid), .data_ready(data_skid_ready), .data_req(data_skid_req),
        .grant_valid(grant_valid), .grant_ready(grant_ready),
        .grant_req(grant_req), .grant_id(grant_id)
    );

    burst_reader reader (
        .aclk(aclk), .rst(rst),
        .req_valid(grant_valid), .req_ready(grant_ready), .req(grant_req), .req_id(grant_id),
        .ar_valid(arvalid), .ar_ready(arready), .ar(ar),
        .r_valid(rvalid), .r_ready(rready), .r(r),
        .inst_rsp_valid(inst_rd_rsp_valid), .inst_rsp_ready(inst_rd_rsp_ready),
        .data_rsp_valid(data_rd_rsp_valid), .data_rsp_ready(data_rd_rsp_ready),
        .rsp(rd_rsp)
    );

    burst_writer writer (
        .aclk(aclk), .rst(rst),
        .req_valid(wr_skid_valid), .req_ready(wr_skid_ready), .req(wr_skid_req),
        .aw_valid(awvalid), .aw_ready(awready), .aw(aw),
        .w_valid(wvalid), .w_ready(wready), .w(w),
        .b_valid(bvalid), .b_ready(bready), .b(b),
        .wr_done(data_wr_done)
    );

endmodule

// ==== source/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter (
    input  logic                               aclk,
    input  logic                               rst,
    input  logic                               inst_valid,
    output logic                               inst_ready,
    input  axi_bridge_pkg::line_rd_req_t       inst_req,
    input  logic                               data_valid,
    output logic                               data_ready,
    input  axi_bridge_pkg::line_rd_req_t       data_req,
    output logic                               grant_valid,
    input  logic                               grant_ready,
    output axi_bridge_pkg::line_rd_req_t       grant_req,
    output logic [axi_bridge_pkg::id_w-1:0]    grant_id
);

    logic last_data;
    logic locked;
    logic locked_sel;
    logic pick_data;
    logic sel_data;

    // round robin on a tie
    always_comb begin
        if (inst_valid && data_valid) begin
            pick_data = !last_data;
        end else begin
            pick_data = data_valid;
        end
    end

    // keep the choice while the reader stalls
    assign sel_data = locked ? locked_sel : pick_data;

    assign grant_valid = inst_valid || data_valid;
    assign grant_req   = sel_data ? data_req : inst_req;
    assign grant_id    = sel_data ? axi_bridge_pkg::data_id : axi_bridge_pkg::inst_id;

    assign inst_ready = grant_ready && inst_valid && !sel_data;
    assign data_ready = grant_ready && data_valid && sel_data;

    always_ff @(posedge aclk) begin
        if (rst) begin
            last_data  <= 1'b1;
            locked     <= 1'b0;
            locked_sel <= 1'b0;
        end else begin
            if (grant_valid && grant_ready) begin
                locked    <= 1'b0;
                last_data <= sel_data;
            end else if (grant_valid) begin
                locked     <= 1'b1;
                locked_sel <= sel_data;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        !(inst_ready && data_ready));

endmodule

// ==== source/req_skid.sv ====
`timescale 1ns/1ps

module req_skid #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   mem [2];
    logic [1:0] count;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       push;
    logic       pop;

    // ready comes from the count register only
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            count  <= 2'd0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // held entry must not move under back-pressure
    assert property (@(posedge aclk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule
